// ==== bench/eth_tx_dma_stimulus.txt ====
// Columns: buffer address, length in bytes, memory seed (all hex)
// A line with length 0 closes the list
00000100 00000001 00000011
00000204 00000002 00000023
00000308 00000003 00000035
00000410 00000004 00000047
00000520 00000005 00000059
00000600 00000040 0000006b
00001ff8 00000028 0000007d
00002f80 000000c8 0000008f
00000000 00000000 00000000

// ==== eth_tx_dma.f ====
common/eth_dma_pkg.sv
common/tx_desc_if.sv
common/burst_buf_if.sv
src/csr_decode.sv
tx_dma/tx_burst_fetch.sv
tx_dma/tx_stream_out.sv
src/eth_tx_dma.sv
bench/eth_tx_dma_properties.sv
bench/eth_tx_dma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f eth_tx_dma.f --top-module eth_tx_dma_tb -Mdir obj_dir > build.log 2>&1 &&
{ ./obj_dir/Veth_tx_dma_tb > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "Testbench failed" sim.log &&
grep -q "Testbench passed" sim.log ||
{ cat build.log sim.log 2>/dev/null; exit 1; }

// ==== bench/eth_tx_dma_tb.sv ====
module eth_tx_dma_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import eth_dma_pkg::*;

    logic        clock;
    logic        reset;
    logic [11:0] s_axi_awaddr_i;
    logic [11:0] s_axi_araddr_i;
    logic [31:0] s_axi_wdata_i;
    logic [31:0] s_axi_rdata_o;
    logic [1:0]  s_axi_bresp_o;
    logic [1:0]  s_axi_rresp_o;
    logic        s_axi_awvalid_i, s_axi_awready_o, s_axi_wvalid_i, s_axi_wready_o;
    logic        s_axi_bvalid_o, s_axi_bready_i;
    logic        s_axi_arvalid_i, s_axi_arready_o, s_axi_rvalid_o, s_axi_rready_i;
    addr_t       m_axi_araddr_o;
    logic [7:0]  m_axi_arlen_o;
    logic        m_axi_arvalid_o, m_axi_arready_i;
    word_t       m_axi_rdata_i;
    logic [1:0]  m_axi_rresp_i;
    logic        m_axi_rlast_i, m_axi_rvalid_i, m_axi_rready_o;
    logic [7:0]  tx_axis_tdata_o;
    logic        tx_axis_tvalid_o, tx_axis_tready_i, tx_axis_tlast_o;
    logic        interrupt_o;

    // Stimulus file, three words per packet
    word_t       stim [0:63];
    word_t       pkt_addr [$];
    word_t       pkt_len [$];
    word_t       pkt_seed [$];

    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_start = 0;
    int          cycle_count = 0;
    int          cycle_limit = 200;
    int unsigned lcg_state = 79;
    logic        stall = 1'b0;

    // Expected packet, shared with the memory model and the stream monitor
    addr_t       exp_base;
    int          exp_len = 0;
    word_t       exp_seed;
    int          rx_count = 0;

    logic        ar_hit;
    logic        r_hit;
    addr_t       ar_addr_s;
    logic [7:0]  ar_len_s;
    addr_t       mem_addr;
    int          mem_left = 0;
    int unsigned rnd;

    eth_tx_dma dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Memory contents as seen by the DMA
    function automatic logic [7:0] mem_byte(input addr_t a, input word_t seed);
        return 8'(a + seed) ^ 8'h5A;
    endfunction

    function automatic word_t mem_word(input addr_t a, input word_t seed);
        word_t w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = mem_byte(a + addr_t'(k), seed);
        end
        return w;
    endfunction

    function automatic logic [11:0] ctrl_reg(input logic [9:0] offset);
        return {REGION_CTRL, offset};
    endfunction

    function automatic logic [11:0] desc_reg(input ptr_t slot, input logic [3:0] field);
        return {REGION_TX_DESC, 2'b00, slot, field};
    endfunction

    function automatic word_t addr_pattern(input int i);
        return word_t'(i + 1) * 32'h9E37_79B9;
    endfunction

    function automatic size_t size_pattern(input int i);
        return size_t'(i * 997 + 13);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_ptr(input string name, input ptr_t got, input ptr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_err_start) tests_failed++;
        $display("test %0d %-26s %s", tests_run, name,
                 (errors == test_err_start) ? "ok" : "FAILED");
        test_err_start = errors;
    endtask

    task automatic csr_write(input logic [11:0] addr, input word_t data);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        s_axi_awaddr_i = addr;
        s_axi_wdata_i = data;
        s_axi_awvalid_i = 1'b1;
        s_axi_wvalid_i = 1'b1;
        s_axi_bready_i = 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clock);
            if (s_axi_awvalid_i && s_axi_awready_o) aw_done = 1'b1;
            if (s_axi_wvalid_i && s_axi_wready_o) w_done = 1'b1;
            @(posedge clock);
            #2;
            if (aw_done) s_axi_awvalid_i = 1'b0;
            if (w_done) s_axi_wvalid_i = 1'b0;
        end
        do @(negedge clock); while (!s_axi_bvalid_o);
        check_resp("s_axi_bresp", s_axi_bresp_o, 2'b00);
        @(posedge clock);
        #2;
        s_axi_bready_i = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output word_t data);
        s_axi_araddr_i = addr;
        s_axi_arvalid_i = 1'b1;
        s_axi_rready_i = 1'b1;
        do @(negedge clock); while (!s_axi_arready_o);
        @(posedge clock);
        #2;
        s_axi_arvalid_i = 1'b0;
        do @(negedge clock); while (!s_axi_rvalid_o);
        data = s_axi_rdata_o;
        check_resp("s_axi_rresp", s_axi_rresp_o, 2'b00);
        @(posedge clock);
        #2;
        s_axi_rready_i = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [11:0] addr, input word_t exp);
        word_t rd;
        csr_read(addr, rd);
        check_word(name, rd, exp);
    endtask

    // Queue one packet at the producer index and wait for the consumer to move
    task automatic run_packet(input int idx, input logic int_on);
        word_t rd;
        ptr_t  out_before;
        ptr_t  slot;
        csr_read(ctrl_reg(REG_TX_OUT), rd);
        out_before = ptr_t'(rd);
        csr_read(ctrl_reg(REG_TX_INP), rd);
        slot = ptr_t'(rd);
        csr_write(desc_reg(slot, DESC_ADDR), pkt_addr[idx]);
        csr_write(desc_reg(slot, DESC_SIZE), pkt_len[idx]);
        exp_base = pkt_addr[idx];
        exp_len = int'(pkt_len[idx]);
        exp_seed = pkt_seed[idx];
        rx_count = 0;
        csr_write(ctrl_reg(REG_TX_INP), word_t'(slot + ptr_t'(1)));
        do csr_read(ctrl_reg(REG_TX_OUT), rd); while (ptr_t'(rd) == out_before);
        check_ptr("TX_OUT", ptr_t'(rd), out_before + ptr_t'(1));
        check_word("packet byte count", word_t'(rx_count), pkt_len[idx]);
        check_flag("interrupt_o", interrupt_o, int_on);
        if (int_on) begin
            csr_write(ctrl_reg(REG_INT_STATUS), 32'h0);
            check_flag("interrupt_o", interrupt_o, 1'b0);
        end
    endtask

    function automatic logic crosses_4k(input int idx);
        return int'(pkt_addr[idx][11:0]) + int'(pkt_len[idx]) > 4096;
    endfunction

    // AXI4 read slave and tready driver
    initial begin
        forever begin
            @(negedge clock);
            ar_hit = m_axi_arvalid_o && m_axi_arready_i;
            r_hit = m_axi_rvalid_i && m_axi_rready_o;
            ar_addr_s = m_axi_araddr_o;
            ar_len_s = m_axi_arlen_o;
            @(posedge clock);
            #2;
            if (reset) begin
                mem_left = 0;
            end else if (ar_hit) begin
                if (int'(ar_addr_s[11:0]) + 4 * (int'(ar_len_s) + 1) > 4096) begin
                    errors++;
                    $display("AR burst at %h with arlen %0d runs over a 4 KB boundary",
                             ar_addr_s, ar_len_s);
                end
                mem_addr = ar_addr_s;
                mem_left = int'(ar_len_s) + 1;
            end else if (r_hit) begin
                mem_addr = mem_addr + addr_t'(4);
                mem_left--;
            end
            rnd = lcg_next();
            m_axi_rvalid_i = (mem_left != 0) && (!stall || rnd[3:2] != 2'b00);
            m_axi_rdata_i = mem_word(mem_addr, exp_seed);
            m_axi_rlast_i = (mem_left == 1);
            m_axi_arready_i = (mem_left == 0) && (!stall || rnd[5]);
            tx_axis_tready_i = !stall || rnd[9:8] != 2'b00;
        end
    end

    // Stream monitor
    always @(negedge clock) begin
        if (!reset && tx_axis_tvalid_o && tx_axis_tready_i) begin
            if (rx_count >= exp_len) begin
                errors++;
                $display("Byte %h arrived after the end of the packet", tx_axis_tdata_o);
            end else begin
                check_byte("tx_axis_tdata", tx_axis_tdata_o,
                           mem_byte(exp_base + addr_t'(rx_count), exp_seed));
                check_flag("tx_axis_tlast", tx_axis_tlast_o, rx_count == exp_len - 1);
            end
            rx_count++;
        end
    end

    initial begin
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a packet never completed", cycle_count);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        word_t rd;
        reset = 1'b1;
        s_axi_awaddr_i = '0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i = '0;
        s_axi_wvalid_i = 1'b0;
        s_axi_bready_i = 1'b0;
        s_axi_araddr_i = '0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i = 1'b0;
        m_axi_arready_i = 1'b0;
        m_axi_rdata_i = '0;
        m_axi_rresp_i = 2'b00;
        m_axi_rlast_i = 1'b0;
        m_axi_rvalid_i = 1'b0;
        tx_axis_tready_i = 1'b1;
        stim = '{default: '0};
        $readmemh("bench/eth_tx_dma_stimulus.txt", stim);
        for (int i = 0; stim[3*i+1] != 0; i++) begin
            pkt_addr.push_back(stim[3*i]);
            pkt_len.push_back(stim[3*i+1]);
            pkt_seed.push_back(stim[3*i+2]);
            cycle_limit += 40 * int'(stim[3*i+1]);
        end
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;

        read_expect("CONFIG", ctrl_reg(REG_CONFIG), 32'h44);
        read_expect("STATUS", ctrl_reg(REG_STATUS), 32'h0);
        read_expect("INT_ENABLE", ctrl_reg(REG_INT_ENABLE), 32'h0);
        read_expect("INT_STATUS", ctrl_reg(REG_INT_STATUS), 32'h0);
        read_expect("TX_INP", ctrl_reg(REG_TX_INP), 32'h0);
        read_expect("TX_OUT", ctrl_reg(REG_TX_OUT), 32'h0);
        read_expect("CONTROL", ctrl_reg(REG_CONTROL), 32'h0);
        read_expect("unmapped", ctrl_reg(10'h010), 32'h0);
        finish_test("reset values");

        for (int i = 0; i < 16; i++) begin
            csr_write(desc_reg(ptr_t'(i), DESC_ADDR), addr_pattern(i));
            csr_write(desc_reg(ptr_t'(i), DESC_SIZE), word_t'(size_pattern(i)));
        end
        for (int i = 0; i < 16; i++) begin
            read_expect("desc addr", desc_reg(ptr_t'(i), DESC_ADDR), addr_pattern(i));
            read_expect("desc size", desc_reg(ptr_t'(i), DESC_SIZE), word_t'(size_pattern(i)));
        end
        csr_write(ctrl_reg(REG_TX_OUT), 32'h5);
        csr_read(ctrl_reg(REG_TX_OUT), rd);
        check_ptr("TX_OUT", ptr_t'(rd), ptr_t'(5));
        csr_write(ctrl_reg(REG_TX_INP), 32'h5);
        csr_write(ctrl_reg(REG_CONTROL), 32'h2);
        // Ignored now that the engine runs
        csr_write(ctrl_reg(REG_TX_OUT), 32'h9);
        csr_read(ctrl_reg(REG_TX_OUT), rd);
        check_ptr("TX_OUT", ptr_t'(rd), ptr_t'(5));
        finish_test("register access");

        foreach (pkt_len[i]) begin
            if (!crosses_4k(i)) run_packet(i, 1'b0);
        end
        finish_test("packet stream");

        foreach (pkt_len[i]) begin
            if (crosses_4k(i)) run_packet(i, 1'b0);
        end
        finish_test("4 KB boundary");

        stall = 1'b1;
        foreach (pkt_len[i]) run_packet(i, 1'b0);
        finish_test("tready and memory stalls");

        csr_write(ctrl_reg(REG_INT_STATUS), 32'h0);
        csr_write(ctrl_reg(REG_INT_ENABLE), 32'h1);
        check_flag("interrupt_o", interrupt_o, 1'b0);
        run_packet(0, 1'b1);
        run_packet(5, 1'b1);
        finish_test("interrupt");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== bench/eth_tx_dma_properties.sv ====
module eth_tx_dma_properties (
    input logic        clock,
    input logic        reset,
    input logic [31:0] m_axi_araddr_o,
    input logic        m_axi_arvalid_o,
    input logic        m_axi_arready_i,
    input logic [7:0]  tx_axis_tdata_o,
    input logic        tx_axis_tvalid_o,
    input logic        tx_axis_tready_i,
    input logic        s_axi_rvalid_o,
    input logic        s_axi_rready_i,
    input logic        s_axi_bvalid_o,
    input logic        s_axi_bready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o))
        else $error("AR request changed before arready");

    // Byte must wait for the sink
    stream_hold: assert property (@(posedge clock) disable iff (reset)
        tx_axis_tvalid_o && !tx_axis_tready_i |=> tx_axis_tvalid_o && $stable(tx_axis_tdata_o))
        else $error("Stream byte changed under back-pressure");

    r_hold: assert property (@(posedge clock) disable iff (reset)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o)
        else $error("Register read response dropped before rready");

    b_hold: assert property (@(posedge clock) disable iff (reset)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
        else $error("Register write response dropped before bready");

endmodule

bind eth_tx_dma eth_tx_dma_properties props_i (.*);

// ==== src/eth_tx_dma.sv ====
module eth_tx_dma (
    input  logic               clock,
    input  logic               reset,
    input  logic [11:0]        s_axi_awaddr_i,
    input  logic               s_axi_awvalid_i,
    output logic               s_axi_awready_o,
    input  logic [31:0]        s_axi_wdata_i,
    input  logic               s_axi_wvalid_i,
    output logic               s_axi_wready_o,
    output logic [1:0]         s_axi_bresp_o,
    output logic               s_axi_bvalid_o,
    input  logic               s_axi_bready_i,
    input  logic [11:0]        s_axi_araddr_i,
    input  logic               s_axi_arvalid_i,
    output logic               s_axi_arready_o,
    output logic [31:0]        s_axi_rdata_o,
    output logic [1:0]         s_axi_rresp_o,
    output logic               s_axi_rvalid_o,
    input  logic               s_axi_rready_i,
    output eth_dma_pkg::addr_t m_axi_araddr_o,
    output logic [7:0]         m_axi_arlen_o,
    output logic               m_axi_arvalid_o,
    input  logic               m_axi_arready_i,
    input  eth_dma_pkg::word_t m_axi_rdata_i,
    input  logic [1:0]         m_axi_rresp_i,
    input  logic               m_axi_rlast_i,
    input  logic               m_axi_rvalid_i,
    output logic               m_axi_rready_o,
    output logic [7:0]         tx_axis_tdata_o,
    output logic               tx_axis_tvalid_o,
    input  logic               tx_axis_tready_i,
    output logic               tx_axis_tlast_o,
    output logic               interrupt_o
);

    tx_desc_if   desc ();
    burst_buf_if burst_buf ();

    // Decode stage
    csr_decode csr_decode_i (
        .clock            (clock),
        .reset            (reset),
        .s_axi_awaddr_i   (s_axi_awaddr_i),
        .s_axi_awvalid_i  (s_axi_awvalid_i),
        .s_axi_awready_o  (s_axi_awready_o),
        .s_axi_wdata_i    (s_axi_wdata_i),
        .s_axi_wvalid_i   (s_axi_wvalid_i),
        .s_axi_wready_o   (s_axi_wready_o),
        .s_axi_bresp_o    (s_axi_bresp_o),
        .s_axi_bvalid_o   (s_axi_bvalid_o),
        .s_axi_bready_i   (s_axi_bready_i),
        .s_axi_araddr_i   (s_axi_araddr_i),
        .s_axi_arvalid_i  (s_axi_arvalid_i),
        .s_axi_arready_o  (s_axi_arready_o),
        .s_axi_rdata_o    (s_axi_rdata_o),
        .s_axi_rresp_o    (s_axi_rresp_o),
        .s_axi_rvalid_o   (s_axi_rvalid_o),
        .s_axi_rready_i   (s_axi_rready_i),
        .tx_axis_tready_i (tx_axis_tready_i),
        .desc             (desc.regs),
        .interrupt_o      (interrupt_o)
    );

    // Execute stage
    tx_burst_fetch tx_burst_fetch_i (
        .clock           (clock),
        .reset           (reset),
        .m_axi_araddr_o  (m_axi_araddr_o),
        .m_axi_arlen_o   (m_axi_arlen_o),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_arready_i (m_axi_arready_i),
        .m_axi_rdata_i   (m_axi_rdata_i),
        .m_axi_rresp_i   (m_axi_rresp_i),
        .m_axi_rlast_i   (m_axi_rlast_i),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .m_axi_rready_o  (m_axi_rready_o),
        .desc            (desc.engine),
        .burst_buf       (burst_buf.fill)
    );

    // Result stage
    tx_stream_out tx_stream_out_i (
        .clock            (clock),
        .reset            (reset),
        .tx_axis_tdata_o  (tx_axis_tdata_o),
        .tx_axis_tvalid_o (tx_axis_tvalid_o),
        .tx_axis_tlast_o  (tx_axis_tlast_o),
        .tx_axis_tready_i (tx_axis_tready_i),
        .burst_buf        (burst_buf.drain)
    );

endmodule

// ==== tx_dma/tx_stream_out.sv ====
module tx_stream_out (
    input  logic       clock,
    input  logic       reset,
    output logic [7:0] tx_axis_tdata_o,
    output logic       tx_axis_tvalid_o,
    output logic       tx_axis_tlast_o,
    input  logic       tx_axis_tready_i,
    burst_buf_if.drain burst_buf
);
    import eth_dma_pkg::*;

    logic [WORD_LOG2-1:0] byte_offs;
    logic                 final_byte;
    logic                 word_end;
    logic                 xfer;

    // Last valid byte of the final word
    assign final_byte = burst_buf.last_word
                     && ({1'b0, byte_offs} == burst_buf.last_bytes - (WORD_LOG2+1)'(1));
    assign word_end   = final_byte || (byte_offs == '1);
    assign xfer       = burst_buf.valid && tx_axis_tready_i;

    // Least significant byte goes out first
    assign tx_axis_tdata_o  = burst_buf.word[8*byte_offs +: 8];
    assign tx_axis_tvalid_o = burst_buf.valid;
    assign tx_axis_tlast_o  = final_byte;

    assign burst_buf.pop  = xfer && word_end;
    assign burst_buf.sent = xfer && final_byte;

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_offs <= '0;
        end else if (xfer) begin
            if (word_end) begin
                byte_offs <= '0;
            end else begin
                byte_offs <= byte_offs + 1'b1;
            end
        end
    end

endmodule

// ==== tx_dma/tx_burst_fetch.sv ====
module tx_burst_fetch (
    input  logic               clock,
    input  logic               reset,
    output eth_dma_pkg::addr_t m_axi_araddr_o,
    output logic [7:0]         m_axi_arlen_o,
    output logic               m_axi_arvalid_o,
    input  logic               m_axi_arready_i,
    input  eth_dma_pkg::word_t m_axi_rdata_i,
    input  logic [1:0]         m_axi_rresp_i,
    input  logic               m_axi_rlast_i,
    input  logic               m_axi_rvalid_i,
    output logic               m_axi_rready_o,
    tx_desc_if.engine          desc,
    burst_buf_if.fill          burst_buf
);
    import eth_dma_pkg::*;

    localparam int ROOM_BITS = 12 - WORD_LOG2;

    word_t              ring [2**BURST_LOG2];
    bptr_t              inp;
    bptr_t              outp;
    bptr_t              free;
    bptr_t              burst_m1;
    bptr_t              clip_m1;
    logic [ROOM_BITS-1:0] room_4k_m1;
    logic               room_ok;
    logic               beat;

    logic               loaded;
    logic               fetch_stop;
    logic               sent_seen;
    logic               rd_cyc;
    logic               rd_err;
    addr_t              pkt_addr;
    size_t              word_left;
    logic [WORD_LOG2:0] last_bytes;

    // One slot stays empty so that full and empty differ
    assign free = outp - inp - bptr_t'(1);
    assign beat = rd_cyc && m_axi_rvalid_i;

    assign room_ok = (word_left >= size_t'(MIN_BURST)) ? (free >= bptr_t'(MIN_BURST))
                                                       : (free != '0);
    assign burst_m1 = (word_left >= size_t'(free)) ? free - bptr_t'(1)
                                                   : bptr_t'(word_left) - bptr_t'(1);

    // Words left in this 4 KB page, minus one
    assign room_4k_m1 = ~pkt_addr[11:WORD_LOG2];
    assign clip_m1 = (room_4k_m1 >= ROOM_BITS'(burst_m1)) ? burst_m1 : bptr_t'(room_4k_m1);

    assign m_axi_rready_o = rd_cyc;

    assign desc.done   = fetch_stop && sent_seen;
    assign desc.rd_cyc = rd_cyc;
    assign desc.rd_err = rd_err;

    assign burst_buf.word       = ring[outp];
    assign burst_buf.valid      = inp != outp;
    assign burst_buf.last_word  = fetch_stop && (outp + bptr_t'(1) == inp);
    assign burst_buf.last_bytes = last_bytes;

    always_ff @(posedge clock) begin
        if (beat) ring[inp] <= m_axi_rdata_i;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            loaded          <= 1'b0;
            fetch_stop      <= 1'b0;
            sent_seen       <= 1'b0;
            rd_cyc          <= 1'b0;
            rd_err          <= 1'b0;
            m_axi_arvalid_o <= 1'b0;
            inp             <= '0;
            outp            <= '0;
        end else if (!desc.start) begin
            loaded     <= 1'b0;
            fetch_stop <= 1'b0;
            sent_seen  <= 1'b0;
            inp        <= '0;
            outp       <= '0;
        end else if (!loaded) begin
            loaded     <= 1'b1;
            rd_err     <= 1'b0;
            pkt_addr   <= {desc.addr[ADDR_BITS-1:WORD_LOG2], {WORD_LOG2{1'b0}}};
            word_left  <= size_t'(desc.size[SIZE_BITS-1:WORD_LOG2])
                        + size_t'(|desc.size[WORD_LOG2-1:0]);
            last_bytes <= (desc.size[WORD_LOG2-1:0] == '0) ? (WORD_LOG2+1)'(WORD_BYTES)
                                                          : {1'b0, desc.size[WORD_LOG2-1:0]};
        end else begin
            if (burst_buf.pop) outp <= outp + bptr_t'(1);
            if (burst_buf.sent) sent_seen <= 1'b1;
            if (rd_cyc) begin
                if (m_axi_arvalid_o && m_axi_arready_i) m_axi_arvalid_o <= 1'b0;
                if (beat) begin
                    inp       <= inp + bptr_t'(1);
                    pkt_addr  <= pkt_addr + ADDR_BITS'(WORD_BYTES);
                    word_left <= word_left - size_t'(1);
                    if (word_left == size_t'(1)) fetch_stop <= 1'b1;
                    if (m_axi_rlast_i) rd_cyc <= 1'b0;
                    if (m_axi_rresp_i != 2'b00) rd_err <= 1'b1;
                end
            end else if (!fetch_stop && room_ok) begin
                rd_cyc          <= 1'b1;
                m_axi_arvalid_o <= 1'b1;
                m_axi_araddr_o  <= pkt_addr;
                m_axi_arlen_o   <= 8'(clip_m1);
            end
        end
    end

endmodule

// ==== src/csr_decode.sv ====
module csr_decode (
    input  logic        clock,
    input  logic        reset,
    input  logic [11:0] s_axi_awaddr_i,
    input  logic        s_axi_awvalid_i,
    output logic        s_axi_awready_o,
    input  logic [31:0] s_axi_wdata_i,
    input  logic        s_axi_wvalid_i,
    output logic        s_axi_wready_o,
    output logic [1:0]  s_axi_bresp_o,
    output logic        s_axi_bvalid_o,
    input  logic        s_axi_bready_i,
    input  logic [11:0] s_axi_araddr_i,
    input  logic        s_axi_arvalid_i,
    output logic        s_axi_arready_o,
    output logic [31:0] s_axi_rdata_o,
    output logic [1:0]  s_axi_rresp_o,
    output logic        s_axi_rvalid_o,
    input  logic        s_axi_rready_i,
    input  logic        tx_axis_tready_i,
    tx_desc_if.regs     desc,
    output logic        interrupt_o
);
    import eth_dma_pkg::*;

    csr_addr_t   rd_addr;
    csr_addr_t   wr_addr;
    logic [31:0] wr_data;
    logic [31:0] rd_data;
    logic        aw_held;
    logic        w_held;
    logic        wr_fire;

    logic        int_enable;
    logic        tx_int;
    logic        tx_enable;
    logic        start;
    ptr_t        tx_inp;
    ptr_t        tx_out;
    addr_t       tx_addr [2**PTR_BITS];
    size_t       tx_size [2**PTR_BITS];

    assign rd_addr = s_axi_araddr_i;
    assign wr_fire = aw_held && w_held && !s_axi_bvalid_o;

    assign s_axi_arready_o = !s_axi_rvalid_o;
    assign s_axi_awready_o = !aw_held && !s_axi_bvalid_o;
    assign s_axi_wready_o  = !w_held && !s_axi_bvalid_o;
    assign s_axi_rresp_o   = 2'b00;
    assign s_axi_bresp_o   = 2'b00;

    assign desc.start  = start;
    assign desc.addr   = tx_addr[tx_out];
    assign desc.size   = tx_size[tx_out];
    assign interrupt_o = int_enable && tx_int;

    always_comb begin
        rd_data = '0;
        if (rd_addr.ctrl.region == REGION_CTRL) begin
            case (rd_addr.ctrl.offset)
                REG_STATUS: begin
                    rd_data[1] = start;
                    rd_data[4] = desc.rd_cyc;
                    rd_data[5] = desc.rd_err;
                end
                REG_INT_ENABLE: rd_data[0] = int_enable;
                REG_INT_STATUS: rd_data[0] = tx_int;
                REG_TX_INP:     rd_data[PTR_BITS-1:0] = tx_inp;
                REG_TX_OUT:     rd_data[PTR_BITS-1:0] = tx_out;
                REG_CONTROL:    rd_data[1] = tx_enable;
                REG_CONFIG: begin
                    rd_data[7:4] = 4'(PTR_BITS);
                    rd_data[3:0] = 4'(BURST_LOG2);
                end
                default: ;
            endcase
        end else if (rd_addr.desc.region == REGION_TX_DESC) begin
            case (rd_addr.desc.field)
                DESC_ADDR: rd_data = tx_addr[rd_addr.desc.pkt];
                DESC_SIZE: rd_data[SIZE_BITS-1:0] = tx_size[rd_addr.desc.pkt];
                default: ;
            endcase
        end
    end

    // Descriptor ring storage
    always_ff @(posedge clock) begin
        if (wr_fire && wr_addr.desc.region == REGION_TX_DESC) begin
            case (wr_addr.desc.field)
                DESC_ADDR: tx_addr[wr_addr.desc.pkt] <= wr_data;
                DESC_SIZE: tx_size[wr_addr.desc.pkt] <= wr_data[SIZE_BITS-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s_axi_rvalid_o <= 1'b0;
            s_axi_bvalid_o <= 1'b0;
            aw_held        <= 1'b0;
            w_held         <= 1'b0;
            int_enable     <= 1'b0;
            tx_int         <= 1'b0;
            tx_enable      <= 1'b0;
            start          <= 1'b0;
            tx_inp         <= '0;
            tx_out         <= '0;
        end else begin
            if (s_axi_rvalid_o) begin
                if (s_axi_rready_i) s_axi_rvalid_o <= 1'b0;
            end else if (s_axi_arvalid_i) begin
                s_axi_rdata_o  <= rd_data;
                s_axi_rvalid_o <= 1'b1;
            end
            if (s_axi_awvalid_i && s_axi_awready_o) begin
                wr_addr <= s_axi_awaddr_i;
                aw_held <= 1'b1;
            end
            if (s_axi_wvalid_i && s_axi_wready_o) begin
                wr_data <= s_axi_wdata_i;
                w_held  <= 1'b1;
            end
            if (s_axi_bvalid_o && s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end else if (wr_fire) begin
                s_axi_bvalid_o <= 1'b1;
                aw_held        <= 1'b0;
                w_held         <= 1'b0;
                if (wr_addr.ctrl.region == REGION_CTRL) begin
                    case (wr_addr.ctrl.offset)
                        REG_INT_ENABLE: int_enable <= wr_data[0];
                        REG_INT_STATUS: tx_int <= wr_data[0];
                        REG_TX_INP:     tx_inp <= wr_data[PTR_BITS-1:0];
                        // Consumer index only moves by hand while stopped
                        REG_TX_OUT:     if (!tx_enable) tx_out <= wr_data[PTR_BITS-1:0];
                        REG_CONTROL:    tx_enable <= wr_data[1];
                        default: ;
                    endcase
                end
            end
            // Packet sequencing
            if (tx_enable && !start && !desc.done && tx_inp != tx_out && tx_axis_tready_i) begin
                start <= 1'b1;
            end else if (start && desc.done) begin
                start  <= 1'b0;
                tx_out <= tx_out + ptr_t'(1);
                tx_int <= 1'b1;
            end
        end
    end

endmodule

// ==== common/burst_buf_if.sv ====
interface burst_buf_if;
    import eth_dma_pkg::*;

    // Head of the burst ring
    word_t              word;
    logic               valid;
    logic               last_word;
    // 1 to 4 bytes valid in the final word
    logic [WORD_LOG2:0] last_bytes;

    // Back from the serializer
    logic               pop;
    logic               sent;

    modport fill (
        output word, valid, last_word, last_bytes,
        input  pop, sent
    );

    modport drain (
        input  word, valid, last_word, last_bytes,
        output pop, sent
    );

endinterface

// ==== common/tx_desc_if.sv ====
interface tx_desc_if;
    import eth_dma_pkg::*;

    // Descriptor of the packet in service
    logic  start;
    addr_t addr;
    size_t size;

    // Engine status back to the registers
    logic  done;
    logic  rd_cyc;
    logic  rd_err;

    modport regs (
        output start, addr, size,
        input  done, rd_cyc, rd_err
    );

    modport engine (
        input  start, addr, size,
        output done, rd_cyc, rd_err
    );

endinterface

// ==== common/eth_dma_pkg.sv ====
package eth_dma_pkg;

    // Datapath sizes
    localparam int ADDR_BITS  = 32;
    localparam int DATA_BITS  = 32;
    localparam int WORD_BYTES = 4;
    localparam int WORD_LOG2  = 2;
    localparam int BURST_LOG2 = 4;
    localparam int MIN_BURST  = 8;
    localparam int PTR_BITS   = 4;
    localparam int SIZE_BITS  = 14;

    // Control region offsets
    localparam logic [9:0] REG_STATUS     = 10'h004;
    localparam logic [9:0] REG_INT_ENABLE = 10'h008;
    localparam logic [9:0] REG_INT_STATUS = 10'h00C;
    localparam logic [9:0] REG_TX_INP     = 10'h018;
    localparam logic [9:0] REG_TX_OUT     = 10'h01C;
    localparam logic [9:0] REG_CONTROL    = 10'h020;
    localparam logic [9:0] REG_CONFIG     = 10'h02C;

    localparam logic [1:0] REGION_CTRL    = 2'd0;
    localparam logic [1:0] REGION_TX_DESC = 2'd3;

    // Field offsets inside one descriptor slot
    localparam logic [3:0] DESC_ADDR = 4'h0;
    localparam logic [3:0] DESC_SIZE = 4'h4;

    typedef struct packed {
        logic [1:0] region;
        logic [9:0] offset;
    } csr_ctrl_t;

    // Whatever is left between region and packet number is ignored
    typedef struct packed {
        logic [1:0]              region;
        logic [5-PTR_BITS:0]     unused;
        logic [PTR_BITS-1:0]     pkt;
        logic [3:0]              field;
    } csr_desc_t;

    typedef union packed {
        csr_ctrl_t ctrl;
        csr_desc_t desc;
    } csr_addr_t;

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [SIZE_BITS-1:0]  size_t;
    typedef logic [DATA_BITS-1:0]  word_t;
    typedef logic [PTR_BITS-1:0]   ptr_t;
    typedef logic [BURST_LOG2-1:0] bptr_t;

endpackage
